/* verilog/switch_params.svh */
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// switch geometry

// ingress and egress port count
`define NUM_PORTS 4

// words held by one page of the shared memory
`define PAGE_WORDS 8

// pages in the shared page memory
`define NUM_PAGES 32

// half-word width on the ports
`define WORD_W 16

// longest packet a source may send, in words
`define MAX_PKT_WORDS 32

`endif

/* verilog/pkt_pkg.sv */
`include "switch_params.svh"

// types seen on the port side of the switch
package pkt_pkg;

    // one half-word on the wire
    typedef logic [`WORD_W-1:0] word_t;

    // port number, also the routing field of the header word
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;

    // valid words in a page, 1 to 8
    typedef logic [$clog2(`PAGE_WORDS):0] word_cnt_t;

    // one page as it moves between ports and the page memory
    typedef struct packed {
        word_t [`PAGE_WORDS-1:0] words;
        word_cnt_t               cnt;
        logic                    sop;   // first page of its packet
        logic                    eop;   // last page of its packet
        port_id_t                dest;
    } page_data_t;

endpackage

/* verilog/mem_pkg.sv */
`include "switch_params.svh"

// types of the shared storage and its control
package mem_pkg;

    // index into the page memory
    typedef logic [$clog2(`NUM_PAGES)-1:0] page_addr_t;

    // request to the page manager
    typedef enum logic [1:0] {
        PM_NONE,
        PM_APPEND,
        PM_POP
    } pm_op_e;

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE,
        ARB_ACK
    } arb_state_e;

endpackage

/* verilog/port_ingress.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

// collects words of one input port into pages and hands them to the arbiter
module port_ingress (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  pkt_pkg::word_t      wr_data,
    output logic                full,
    output logic                wr_req,
    output pkt_pkg::page_data_t wr_page,
    input  logic                wr_ack
);

    localparam int IDX_W  = $clog2(`PAGE_WORDS);
    localparam int DEST_W = $bits(pkt_pkg::port_id_t);

    pkt_pkg::word_t [`PAGE_WORDS-1:0] words;
    pkt_pkg::word_cnt_t               cnt;
    pkt_pkg::port_id_t                dest;
    logic                             page_sop;
    logic                             page_eop;
    logic                             accept;
    logic                             page_done;

    assign accept = wr_vld && !full;

    // page closes on its 8th word or on the packet end
    assign page_done = accept &&
                       (wr_eop || cnt == pkt_pkg::word_cnt_t'(`PAGE_WORDS - 1));

    // handshake and fill count
    always_ff @(posedge clk) begin
        if (reset) begin
            full   <= 1'b0;
            wr_req <= 1'b0;
            cnt    <= '0;
        end else begin
            if (accept) begin
                cnt <= cnt + 1'b1;
            end
            if (page_done) begin
                full   <= 1'b1;
                wr_req <= 1'b1;
            end
            if (wr_req && wr_ack) begin
                wr_req <= 1'b0;
                cnt    <= '0;
            end else if (full && !wr_req && !wr_ack) begin
                // ack has fallen, buffer free again
                full <= 1'b0;
            end
        end
    end

    // page payload
    always_ff @(posedge clk) begin
        if (accept) begin
            words[cnt[IDX_W-1:0]] <= wr_data;
            page_eop              <= wr_eop;
            if (cnt == '0) begin
                page_sop <= wr_sop;
            end
            // header word carries the route
            if (wr_sop) begin
                dest <= wr_data[DEST_W-1:0];
            end
        end
    end

    always_comb begin
        wr_page.words = words;
        wr_page.cnt   = cnt;
        wr_page.sop   = page_sop;
        wr_page.eop   = page_eop;
        wr_page.dest  = dest;
    end

endmodule

/* verilog/port_egress.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

// streams pages of one output queue, with one page prefetched
module port_egress (
    input  logic                clk,
    input  logic                reset,
    output logic                rd_req,
    input  logic                rd_ack,
    input  pkt_pkg::page_data_t rd_page,
    input  logic                ready,
    output logic                rd_sop,
    output logic                rd_eop,
    output logic                rd_vld,
    output pkt_pkg::word_t      rd_data
);

    localparam int IDX_W = $clog2(`PAGE_WORDS);

    pkt_pkg::page_data_t cur;
    pkt_pkg::page_data_t pf;
    logic                pf_valid;
    logic [IDX_W-1:0]    idx;
    logic                last_word;
    logic                move;
    logic                got;

    assign last_word = (pkt_pkg::word_cnt_t'(idx) + 1'b1 == cur.cnt);
    assign move      = rd_vld && ready;
    assign got       = rd_req && rd_ack;

    assign rd_data = cur.words[idx];
    assign rd_sop  = rd_vld && cur.sop && (idx == '0);
    assign rd_eop  = rd_vld && cur.eop && last_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld   <= 1'b0;
            rd_req   <= 1'b0;
            pf_valid <= 1'b0;
            idx      <= '0;
        end else begin
            if (move) begin
                if (last_word) begin
                    // prefetched page follows without a gap
                    idx      <= '0;
                    rd_vld   <= pf_valid;
                    pf_valid <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
            if (got) begin
                rd_req <= 1'b0;
                if (!rd_vld || (move && last_word)) begin
                    rd_vld <= 1'b1;
                    idx    <= '0;
                end else begin
                    pf_valid <= 1'b1;
                end
            end else if (!rd_req && !rd_ack && !pf_valid) begin
                rd_req <= 1'b1;
            end
        end
    end

    // page registers
    always_ff @(posedge clk) begin
        if (move && last_word && pf_valid) begin
            cur <= pf;
        end
        if (got) begin
            if (!rd_vld || (move && last_word)) begin
                cur <= rd_page;
            end else begin
                pf <= rd_page;
            end
        end
    end

endmodule

/* verilog/page_manager.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

// free list, next-page table, pending chains and output queues
module page_manager (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_pkg::pm_op_e       pm_op,
    input  pkt_pkg::port_id_t     pm_src,
    input  pkt_pkg::port_id_t     pm_dest,
    input  logic                  pm_eop,
    input  mem_pkg::page_addr_t   pm_return,
    output mem_pkg::page_addr_t   alloc_page,
    output mem_pkg::page_addr_t   head_page,
    output logic                  free_avail,
    output logic [`NUM_PORTS-1:0] queue_ready
);

    localparam int CNT_W = $clog2(`NUM_PAGES) + 1;

    mem_pkg::page_addr_t   free_ring [`NUM_PAGES];
    mem_pkg::page_addr_t   free_rd;
    mem_pkg::page_addr_t   free_wr;
    logic [CNT_W-1:0]      free_cnt;
    mem_pkg::page_addr_t   next_page [`NUM_PAGES];
    // pending chain per source
    mem_pkg::page_addr_t   chain_head [`NUM_PORTS];
    mem_pkg::page_addr_t   chain_tail [`NUM_PORTS];
    logic [CNT_W-1:0]      chain_cnt [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] chain_open;
    // packet queue per destination
    mem_pkg::page_addr_t   q_head [`NUM_PORTS];
    mem_pkg::page_addr_t   q_tail [`NUM_PORTS];
    logic [CNT_W-1:0]      q_cnt [`NUM_PORTS];
    mem_pkg::page_addr_t   pkt_head;
    logic [CNT_W-1:0]      pkt_cnt;
    logic                  do_append;
    logic                  do_pop;

    assign do_append  = (pm_op == mem_pkg::PM_APPEND);
    assign do_pop     = (pm_op == mem_pkg::PM_POP);
    assign alloc_page = free_ring[free_rd];
    assign head_page  = q_head[pm_dest];
    assign free_avail = (free_cnt != '0);

    always_comb begin
        for (int d = 0; d < `NUM_PORTS; d++) begin
            queue_ready[d] = (q_cnt[d] != '0);
        end
    end

    // chain as it stands with the new page added
    assign pkt_head = chain_open[pm_src] ? chain_head[pm_src] : alloc_page;
    assign pkt_cnt  = chain_open[pm_src] ? chain_cnt[pm_src] + 1'b1 : CNT_W'(1);

    // free ring starts holding every page
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_PAGES; i++) begin
                free_ring[i] <= mem_pkg::page_addr_t'(i);
            end
            free_rd  <= '0;
            free_wr  <= '0;
            free_cnt <= CNT_W'(`NUM_PAGES);
        end else if (do_append) begin
            free_rd  <= free_rd + 1'b1;
            free_cnt <= free_cnt - 1'b1;
        end else if (do_pop) begin
            free_ring[free_wr] <= pm_return;
            free_wr            <= free_wr + 1'b1;
            free_cnt           <= free_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chain_open <= '0;
            for (int d = 0; d < `NUM_PORTS; d++) begin
                q_cnt[d]     <= '0;
                chain_cnt[d] <= '0;
            end
        end else if (do_append) begin
            chain_open[pm_src] <= !pm_eop;
            chain_cnt[pm_src]  <= pm_eop ? '0 : pkt_cnt;
            if (pm_eop) begin
                q_cnt[pm_dest] <= q_cnt[pm_dest] + pkt_cnt;
            end
        end else if (do_pop) begin
            q_cnt[pm_dest] <= q_cnt[pm_dest] - 1'b1;
        end
    end

    // links and queue pointers
    always_ff @(posedge clk) begin
        if (do_append) begin
            if (chain_open[pm_src]) begin
                next_page[chain_tail[pm_src]] <= alloc_page;
            end
            chain_head[pm_src] <= pkt_head;
            chain_tail[pm_src] <= alloc_page;
            if (pm_eop) begin
                // splice the whole packet onto its queue
                if (q_cnt[pm_dest] == '0) begin
                    q_head[pm_dest] <= pkt_head;
                end else begin
                    next_page[q_tail[pm_dest]] <= pkt_head;
                end
                q_tail[pm_dest] <= alloc_page;
            end
        end else if (do_pop) begin
            q_head[pm_dest] <= next_page[q_head[pm_dest]];
        end
    end

endmodule

/* verilog/page_arbiter.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

// round-robin arbiter over ingress writers and egress readers
module page_arbiter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [`NUM_PORTS-1:0]                wr_req,
    input  pkt_pkg::page_data_t [`NUM_PORTS-1:0] wr_page,
    output logic [`NUM_PORTS-1:0]                wr_ack,
    input  logic [`NUM_PORTS-1:0]                rd_req,
    output logic [`NUM_PORTS-1:0]                rd_ack,
    output pkt_pkg::page_data_t                  rd_page,
    output mem_pkg::pm_op_e                      pm_op,
    output pkt_pkg::port_id_t                    pm_src,
    output pkt_pkg::port_id_t                    pm_dest,
    output logic                                 pm_eop,
    output mem_pkg::page_addr_t                  pm_return,
    input  mem_pkg::page_addr_t                  alloc_page,
    input  mem_pkg::page_addr_t                  head_page,
    input  logic                                 free_avail,
    input  logic [`NUM_PORTS-1:0]                queue_ready
);

    localparam int SLOTS  = 2 * `NUM_PORTS;
    localparam int SLOT_W = $clog2(SLOTS);

    typedef logic [SLOT_W-1:0] slot_t;

    pkt_pkg::page_data_t page_mem [`NUM_PAGES];
    mem_pkg::arb_state_e state;
    slot_t               rr_ptr;
    slot_t               sel;
    slot_t               pick;
    logic                found;
    logic [SLOTS-1:0]    eligible;
    logic                sel_rd;
    pkt_pkg::port_id_t   sel_port;
    logic                sel_req;

    // writes in slots 0..3, reads in slots 4..7
    assign eligible = {rd_req & queue_ready, wr_req & {`NUM_PORTS{free_avail}}};
    assign sel_rd   = sel[SLOT_W-1];
    assign sel_port = sel[SLOT_W-2:0];
    assign sel_req  = sel_rd ? rd_req[sel_port] : wr_req[sel_port];

    always_comb begin
        slot_t idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < SLOTS; i++) begin
            idx = rr_ptr + slot_t'(i);
            if (!found && eligible[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // page manager moves in the same edge as the memory access
    assign pm_op     = (state != mem_pkg::ARB_SERVE) ? mem_pkg::PM_NONE :
                       sel_rd ? mem_pkg::PM_POP : mem_pkg::PM_APPEND;
    assign pm_src    = sel_port;
    assign pm_dest   = sel_rd ? sel_port : wr_page[sel_port].dest;
    assign pm_eop    = wr_page[sel_port].eop;
    assign pm_return = head_page;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mem_pkg::ARB_IDLE;
            rr_ptr <= '0;
            sel    <= '0;
            wr_ack <= '0;
            rd_ack <= '0;
        end else begin
            case (state)
                mem_pkg::ARB_IDLE: begin
                    if (found) begin
                        sel    <= pick;
                        rr_ptr <= pick + 1'b1;
                        state  <= mem_pkg::ARB_SERVE;
                    end
                end
                mem_pkg::ARB_SERVE: begin
                    if (sel_rd) begin
                        rd_ack[sel_port] <= 1'b1;
                    end else begin
                        wr_ack[sel_port] <= 1'b1;
                    end
                    state <= mem_pkg::ARB_ACK;
                end
                mem_pkg::ARB_ACK: begin
                    if (!sel_req) begin
                        wr_ack <= '0;
                        rd_ack <= '0;
                        state  <= mem_pkg::ARB_IDLE;
                    end
                end
                default: state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    // shared page memory, read data held through the ack
    always_ff @(posedge clk) begin
        if (state == mem_pkg::ARB_SERVE) begin
            if (sel_rd) begin
                rd_page <= page_mem[head_page];
            end else begin
                page_mem[alloc_page] <= wr_page[sel_port];
            end
        end
    end

endmodule

/* verilog/packet_switch.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

// shared-buffer packet switch, four in and four out
module packet_switch (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [`NUM_PORTS-1:0]            wr_sop,
    input  logic [`NUM_PORTS-1:0]            wr_eop,
    input  logic [`NUM_PORTS-1:0]            wr_vld,
    input  pkt_pkg::word_t [`NUM_PORTS-1:0]  wr_data,
    output logic [`NUM_PORTS-1:0]            full,
    input  logic [`NUM_PORTS-1:0]            ready,
    output logic [`NUM_PORTS-1:0]            rd_sop,
    output logic [`NUM_PORTS-1:0]            rd_eop,
    output logic [`NUM_PORTS-1:0]            rd_vld,
    output pkt_pkg::word_t [`NUM_PORTS-1:0]  rd_data
);

    logic [`NUM_PORTS-1:0]                wr_req;
    logic [`NUM_PORTS-1:0]                wr_ack;
    pkt_pkg::page_data_t [`NUM_PORTS-1:0] wr_page;
    logic [`NUM_PORTS-1:0]                rd_req;
    logic [`NUM_PORTS-1:0]                rd_ack;
    pkt_pkg::page_data_t                  rd_page;
    mem_pkg::pm_op_e                      pm_op;
    pkt_pkg::port_id_t                    pm_src;
    pkt_pkg::port_id_t                    pm_dest;
    logic                                 pm_eop;
    mem_pkg::page_addr_t                  pm_return;
    mem_pkg::page_addr_t                  alloc_page;
    mem_pkg::page_addr_t                  head_page;
    logic                                 free_avail;
    logic [`NUM_PORTS-1:0]                queue_ready;

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        port_ingress u_ingress (
            .clk     (clk),
            .reset   (reset),
            .wr_sop  (wr_sop[p]),
            .wr_eop  (wr_eop[p]),
            .wr_vld  (wr_vld[p]),
            .wr_data (wr_data[p]),
            .full    (full[p]),
            .wr_req  (wr_req[p]),
            .wr_page (wr_page[p]),
            .wr_ack  (wr_ack[p])
        );

        port_egress u_egress (
            .clk     (clk),
            .reset   (reset),
            .rd_req  (rd_req[p]),
            .rd_ack  (rd_ack[p]),
            .rd_page (rd_page),
            .ready   (ready[p]),
            .rd_sop  (rd_sop[p]),
            .rd_eop  (rd_eop[p]),
            .rd_vld  (rd_vld[p]),
            .rd_data (rd_data[p])
        );
    end

    page_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .wr_req      (wr_req),
        .wr_page     (wr_page),
        .wr_ack      (wr_ack),
        .rd_req      (rd_req),
        .rd_ack      (rd_ack),
        .rd_page     (rd_page),
        .pm_op       (pm_op),
        .pm_src      (pm_src),
        .pm_dest     (pm_dest),
        .pm_eop      (pm_eop),
        .pm_return   (pm_return),
        .alloc_page  (alloc_page),
        .head_page   (head_page),
        .free_avail  (free_avail),
        .queue_ready (queue_ready)
    );

    page_manager u_page_manager (
        .clk         (clk),
        .reset       (reset),
        .pm_op       (pm_op),
        .pm_src      (pm_src),
        .pm_dest     (pm_dest),
        .pm_eop      (pm_eop),
        .pm_return   (pm_return),
        .alloc_page  (alloc_page),
        .head_page   (head_page),
        .free_avail  (free_avail),
        .queue_ready (queue_ready)
    );

endmodule

/* verif/tb_packet_switch.sv */
`timescale 1ns/1ns
`include "switch_params.svh"

module tb_packet_switch;

    localparam int BURST_PKTS    = 400;
    localparam int SEND_TIMEOUT  = 200000;
    localparam int DRAIN_TIMEOUT = 50000;

    logic                             clk;
    logic                             reset;
    logic [`NUM_PORTS-1:0]            wr_sop;
    logic [`NUM_PORTS-1:0]            wr_eop;
    logic [`NUM_PORTS-1:0]            wr_vld;
    pkt_pkg::word_t [`NUM_PORTS-1:0]  wr_data;
    logic [`NUM_PORTS-1:0]            full;
    logic [`NUM_PORTS-1:0]            ready;
    logic [`NUM_PORTS-1:0]            rd_sop;
    logic [`NUM_PORTS-1:0]            rd_eop;
    logic [`NUM_PORTS-1:0]            rd_vld;
    pkt_pkg::word_t [`NUM_PORTS-1:0]  rd_data;

    logic [31:0]    rng;
    int             checks;
    int             value_errors;
    int             other_errors;
    logic           timed_out;
    // one packet in progress per input
    pkt_pkg::word_t src_words [`NUM_PORTS][`MAX_PKT_WORDS];
    int             plen [`NUM_PORTS];
    int             pos [`NUM_PORTS];
    int             gap [`NUM_PORTS];
    logic [11:0]    seq [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] closing;
    int             pkts_started;
    int             burst_size;
    // reference model with one queue per source/destination pair
    pkt_pkg::word_t exp_words [`NUM_PORTS*`NUM_PORTS][$];
    int             exp_len [`NUM_PORTS*`NUM_PORTS][$];
    // receiver side
    logic [`NUM_PORTS-1:0] in_pkt;
    int             cur_pair [`NUM_PORTS];
    int             cur_len [`NUM_PORTS];
    int             cur_idx [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] held;
    logic [`NUM_PORTS-1:0] held_sop;
    logic [`NUM_PORTS-1:0] held_eop;
    pkt_pkg::word_t held_data [`NUM_PORTS];

    packet_switch dut (
        .clk     (clk),
        .reset   (reset),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // LCG step returning its upper bits modulo n
    function automatic int next_rand(input int n);
        rng = rng * 32'd1664525 + 32'd1013904223;
        return int'(rng[30:15]) % n;
    endfunction

    task automatic check_value(input string name, input int port,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            value_errors++;
            $display("ERROR: %s[%0d] got %h expected %h", name, port, got, exp);
        end
    endtask

    function automatic logic model_empty();
        for (int i = 0; i < `NUM_PORTS * `NUM_PORTS; i++) begin
            if (exp_len[i].size() != 0 || exp_words[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // header holds destination, source and sequence from bit 0 up
    task automatic start_packet(input int p);
        int len;
        int dest;
        int pair;
        len  = 1 + next_rand(`MAX_PKT_WORDS);
        dest = next_rand(`NUM_PORTS);
        src_words[p][0] = {seq[p], 2'(p), 2'(dest)};
        for (int i = 1; i < len; i++) begin
            src_words[p][i] = pkt_pkg::word_t'(next_rand(65536));
        end
        pair = p * `NUM_PORTS + dest;
        exp_len[pair].push_back(len);
        for (int i = 0; i < len; i++) begin
            exp_words[pair].push_back(src_words[p][i]);
        end
        seq[p]  = seq[p] + 1'b1;
        plen[p] = len;
        pos[p]  = 0;
    endtask

    // one clock of stimulus 2 ns after the rising edge
    task automatic drive_cycle();
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (closing[p]) begin
                check_value("full", p, full[p], 1);
            end
            closing[p] = 1'b0;
            wr_vld[p]  = 1'b0;
            wr_sop[p]  = 1'b0;
            wr_eop[p]  = 1'b0;
            if (gap[p] > 0) begin
                gap[p]--;
            end else if (pos[p] == plen[p] && pkts_started < burst_size) begin
                start_packet(p);
                pkts_started++;
            end
            if (gap[p] == 0 && pos[p] < plen[p] && !full[p]) begin
                wr_vld[p]  = 1'b1;
                wr_data[p] = src_words[p][pos[p]];
                wr_sop[p]  = (pos[p] == 0);
                wr_eop[p]  = (pos[p] == plen[p] - 1);
                // page closes on its last slot or at the packet end
                closing[p] = wr_eop[p] || (pos[p] % `PAGE_WORDS == `PAGE_WORDS - 1);
                if (wr_eop[p]) begin
                    gap[p] = next_rand(4);
                end
                pos[p]++;
            end
            ready[p] = (next_rand(4) != 0);
        end
    endtask

    task automatic send_burst(input int count);
        int cycles;
        logic busy;
        cycles       = 0;
        busy         = 1'b1;
        burst_size   = count;
        pkts_started = 0;
        while (!timed_out && (pkts_started < burst_size || busy)) begin
            @(posedge clk);
            #2;
            drive_cycle();
            busy = 1'b0;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                busy = busy || (pos[p] < plen[p]);
            end
            cycles++;
            if (cycles > SEND_TIMEOUT) begin
                timed_out = 1'b1;
                other_errors++;
                $display("timeout: inputs did not take all %0d packets", count);
            end
        end
    endtask

    task automatic drain_queues();
        int cycles;
        cycles = 0;
        while (!timed_out && !model_empty()) begin
            @(posedge clk);
            #2;
            drive_cycle();
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                timed_out = 1'b1;
                other_errors++;
                $display("timeout: packets still expected on the outputs");
            end
        end
    endtask

    // one word leaves output j on the coming edge
    task automatic take_word(input int j);
        pkt_pkg::word_t w;
        int pr;
        w  = rd_data[j];
        pr = int'(w[3:2]) * `NUM_PORTS + j;
        if (!in_pkt[j]) begin
            assert (rd_sop[j]) else begin
                other_errors++;
                $display("output %0d sent a word outside any packet", j);
            end
            assert (exp_len[pr].size() != 0) else begin
                other_errors++;
                $display("output %0d sent a packet that no source sent", j);
            end
            if (!rd_sop[j] || exp_len[pr].size() == 0) begin
                return;
            end
            check_value("rd_data.dest", j, w[1:0], j);
            in_pkt[j]   = 1'b1;
            cur_pair[j] = pr;
            cur_len[j]  = exp_len[pr].pop_front();
            cur_idx[j]  = 0;
        end
        check_value("rd_data", j, w, exp_words[cur_pair[j]].pop_front());
        check_value("rd_sop", j, rd_sop[j], cur_idx[j] == 0);
        check_value("rd_eop", j, rd_eop[j], cur_idx[j] == cur_len[j] - 1);
        cur_idx[j]++;
        if (cur_idx[j] == cur_len[j]) begin
            in_pkt[j] = 1'b0;
        end
    endtask

    // outputs sampled mid-cycle away from both edges
    always @(negedge clk) begin
        if (!reset) begin
            for (int j = 0; j < `NUM_PORTS; j++) begin
                if (held[j]) begin
                    check_value("rd_vld", j, rd_vld[j], 1);
                    check_value("rd_data", j, rd_data[j], held_data[j]);
                    check_value("rd_sop", j, rd_sop[j], held_sop[j]);
                    check_value("rd_eop", j, rd_eop[j], held_eop[j]);
                end
                held[j]      = rd_vld[j] && !ready[j];
                held_data[j] = rd_data[j];
                held_sop[j]  = rd_sop[j];
                held_eop[j]  = rd_eop[j];
                if (rd_vld[j] && ready[j]) begin
                    take_word(j);
                end
            end
        end
    end

    task automatic report();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        rng          = 32'he84b;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_vld       = '0;
        wr_data      = '0;
        ready        = '0;
        closing      = '0;
        in_pkt       = '0;
        held         = '0;
        pkts_started = 0;
        burst_size   = 0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            plen[p] = 0;
            pos[p]  = 0;
            gap[p]  = 0;
            seq[p]  = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        for (int p = 0; p < `NUM_PORTS; p++) begin
            check_value("full", p, full[p], 0);
            check_value("rd_vld", p, rd_vld[p], 0);
            check_value("rd_sop", p, rd_sop[p], 0);
            check_value("rd_eop", p, rd_eop[p], 0);
        end
        // second burst only works if every page came back
        for (int b = 0; b < 2; b++) begin
            if (!timed_out) begin
                send_burst(BURST_PKTS);
                drain_queues();
            end
        end
        report();
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/pkt_pkg.sv
verilog/mem_pkg.sv
verilog/port_ingress.sv
verilog/port_egress.sv
verilog/page_manager.sv
verilog/page_arbiter.sv
verilog/packet_switch.sv
verif/tb_packet_switch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_packet_switch
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
